// ==== hw/rename_pkg.sv ====
// Tags are 6 bits wide, so a core built on this package has at most 64 physical registers.
package rename_pkg;

  localparam int ARCH_W    = 5;
  localparam int PHYS_W    = 6;
  localparam int ARCH_REGS = 32; // x0 to x31.

  typedef logic [ARCH_W-1:0] arch_reg_t;
  typedef logic [PHYS_W-1:0] phys_tag_t;

  // One decoded instruction from the decoder, 17 bits.
  typedef struct packed {
    arch_reg_t rs1;
    arch_reg_t rs2;
    arch_reg_t rd;
    logic      writes; // Instruction writes rd.
    logic      jumps;  // Branch or jump.
  } rename_in_s;

  // One renamed instruction towards dispatch, 32 bits.
  typedef struct packed {
    phys_tag_t ps1;
    phys_tag_t ps2;
    phys_tag_t pd;     // Zero when no register was taken.
    phys_tag_t old_pd; // Freed at retire.
    arch_reg_t rd;
    logic      writes;
    logic      jumps;
    logic      tag;    // Speculative.
  } rename_out_s;

  // Pairs are packed as [1:0] with element 0 the older instruction.

endpackage

// ==== hw/rename_table.sv ====
// Resets to the identity map. Entry 0 reads as tag 0 and is never written, and slot 1 wins on a shared rd.
`timescale 1ns/1ns

module rename_table (
  input  logic                        gsi,
  input  logic                        rst_n,
  input  rename_pkg::arch_reg_t [5:0] rd_addr,
  output rename_pkg::phys_tag_t [5:0] rd_tag,
  input  logic                  [1:0] wr_en,
  input  rename_pkg::arch_reg_t [1:0] wr_addr,
  input  rename_pkg::phys_tag_t [1:0] wr_tag
);
  import rename_pkg::*;

  phys_tag_t map_q [ARCH_REGS];

  // Six combinational lookups.
  always_comb begin
    for (int k = 0; k < 6; k++) begin
      if (rd_addr[k] == '0) begin
        rd_tag[k] = '0;
      end else begin
        rd_tag[k] = map_q[rd_addr[k]];
      end
    end
  end

  always_ff @(posedge gsi or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= phys_tag_t'(i); // Identity.
      end
    end else begin
      if (wr_en[0]) begin
        map_q[wr_addr[0]] <= wr_tag[0];
      end
      // Later assignment takes priority.
      if (wr_en[1]) begin
        map_q[wr_addr[1]] <= wr_tag[1];
      end
    end
  end

  // The renamer must filter x0 destinations before they reach the table.
  a_no_x0_write: assert property (
    @(posedge gsi) disable iff (!rst_n)
    !(wr_en[0] && wr_addr[0] == '0) && !(wr_en[1] && wr_addr[1] == '0)
  ) else $error("rename_table: write to x0");

endmodule

// ==== hw/free_list.sv ====
// NUM_PHYS must lie in 33..64. Pops are issued only when free_count covers them, and tag 0 is never retired.
`timescale 1ns/1ns

module free_list #(
  parameter int NUM_PHYS = 64
) (
  input  logic                        gsi,
  input  logic                        rst_n,
  input  logic                  [1:0] alloc_num,
  output rename_pkg::phys_tag_t [1:0] alloc_tag,
  output logic                  [6:0] free_count,
  input  logic                        retire_valid,
  input  rename_pkg::phys_tag_t       retire_tag
);
  import rename_pkg::*;

  localparam int PW = $clog2(NUM_PHYS);

  typedef logic [PW-1:0] ptr_t;

  phys_tag_t  ring_q [NUM_PHYS];
  ptr_t       head_q;
  ptr_t       tail_q;
  logic [6:0] count_q;

  if (NUM_PHYS < ARCH_REGS + 1 || NUM_PHYS > 64) begin : g_bad_size
    $error("free_list: NUM_PHYS out of range");
  end

  // Advance a pointer around a ring that need not be a power of two.
  function automatic ptr_t ptr_add(input ptr_t p, input int unsigned n);
    int unsigned s;
    s = int'(p) + n;
    if (s >= NUM_PHYS) begin
      s = s - NUM_PHYS;
    end
    return ptr_t'(s);
  endfunction

  assign alloc_tag[0] = ring_q[head_q];
  assign alloc_tag[1] = ring_q[ptr_add(head_q, 1)];
  assign free_count   = count_q;

  always_ff @(posedge gsi or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_PHYS; i++) begin
        ring_q[i] <= (i < NUM_PHYS - ARCH_REGS) ? phys_tag_t'(ARCH_REGS + i) : '0;
      end
      head_q  <= '0;
      tail_q  <= ptr_t'(NUM_PHYS - ARCH_REGS);
      count_q <= 7'(NUM_PHYS - ARCH_REGS);
    end else begin
      if (retire_valid) begin
        ring_q[tail_q] <= retire_tag;
        tail_q         <= ptr_add(tail_q, 1);
      end
      head_q  <= ptr_add(head_q, int'(alloc_num)); // Zero leaves it put.
      count_q <= count_q + 7'(retire_valid) - 7'(alloc_num);
    end
  end

  // Renamer asks only for what is there.
  a_no_underflow: assert property (
    @(posedge gsi) disable iff (!rst_n)
    7'(alloc_num) <= count_q
  ) else $error("free_list: pop beyond count");

  // Preload plus the 31 architectural tags that can come back after being replaced.
  a_count_bound: assert property (
    @(posedge gsi) disable iff (!rst_n)
    int'(count_q) <= (NUM_PHYS - ARCH_REGS) + (ARCH_REGS - 1)
  ) else $error("free_list: count above bound");

endmodule

// ==== hw/resolver.sv ====
// One pair in flight at a time. The decoder and dispatch must follow the four-phase order, and no checkpoint is kept for a mispredict.
`timescale 1ns/1ns

module resolver #(
  parameter int NUM_PHYS = 64
) (
  input  logic                          gsi,
  input  logic                          rst_n,
  input  logic                          in_req,
  input  rename_pkg::rename_in_s  [1:0] in_pair,
  output logic                          in_ack,
  output logic                          stall,
  output logic                          out_req,
  output rename_pkg::rename_out_s [1:0] out_pair,
  input  logic                          out_ack,
  input  logic                          branch_resolved,
  output rename_pkg::arch_reg_t   [5:0] map_addr,
  input  rename_pkg::phys_tag_t   [5:0] map_tag,
  output logic                    [1:0] map_wr_en,
  output rename_pkg::arch_reg_t   [1:0] map_wr_addr,
  output rename_pkg::phys_tag_t   [1:0] map_wr_tag,
  input  logic                    [6:0] free_count,
  input  rename_pkg::phys_tag_t   [1:0] alloc_tag,
  output logic                    [1:0] alloc_num
);
  import rename_pkg::*;

  logic              [1:0] need;
  logic              [1:0] need_cnt;
  logic                    enough;
  logic                    idle;
  logic                    accept;
  logic                    spec_q;
  logic                    byp_rs1;
  logic                    byp_rs2;
  logic                    byp_rd;
  phys_tag_t               pd0;
  phys_tag_t               pd1;
  rename_out_s       [1:0] nxt_pair;

  // Table read order is rs1, rs2, rd for slot 0 and then slot 1.
  assign map_addr[0] = in_pair[0].rs1;
  assign map_addr[1] = in_pair[0].rs2;
  assign map_addr[2] = in_pair[0].rd;
  assign map_addr[3] = in_pair[1].rs1;
  assign map_addr[4] = in_pair[1].rs2;
  assign map_addr[5] = in_pair[1].rd;

  assign need[0]  = in_pair[0].writes && (in_pair[0].rd != '0);
  assign need[1]  = in_pair[1].writes && (in_pair[1].rd != '0);
  assign need_cnt = {1'b0, need[0]} + {1'b0, need[1]};

  assign enough = free_count >= 7'(need_cnt);
  assign idle   = !in_ack && !out_req && !out_ack; // Both exchanges at rest.
  assign accept = in_req && idle && enough;
  assign stall  = in_req && !in_ack && !enough;

  // Slot 1 takes the second tag only when slot 0 used the first.
  assign pd0 = need[0] ? alloc_tag[0] : '0;
  assign pd1 = need[1] ? (need[0] ? alloc_tag[1] : alloc_tag[0]) : '0;

  // need[0] already excludes x0.
  assign byp_rs1 = need[0] && (in_pair[1].rs1 == in_pair[0].rd);
  assign byp_rs2 = need[0] && (in_pair[1].rs2 == in_pair[0].rd);
  assign byp_rd  = need[0] && (in_pair[1].rd == in_pair[0].rd);

  assign map_wr_en      = accept ? need : 2'b00;
  assign map_wr_addr[0] = in_pair[0].rd;
  assign map_wr_addr[1] = in_pair[1].rd;
  assign map_wr_tag[0]  = pd0;
  assign map_wr_tag[1]  = pd1;
  assign alloc_num      = accept ? need_cnt : 2'd0;

  always_comb begin
    nxt_pair[0].ps1    = map_tag[0];
    nxt_pair[0].ps2    = map_tag[1];
    nxt_pair[0].pd     = pd0;
    nxt_pair[0].old_pd = need[0] ? map_tag[2] : '0;
    nxt_pair[0].rd     = in_pair[0].rd;
    nxt_pair[0].writes = in_pair[0].writes;
    nxt_pair[0].jumps  = in_pair[0].jumps;
    nxt_pair[0].tag    = in_pair[0].jumps ? 1'b0 : spec_q;

    nxt_pair[1].ps1    = byp_rs1 ? pd0 : map_tag[3];
    nxt_pair[1].ps2    = byp_rs2 ? pd0 : map_tag[4];
    nxt_pair[1].pd     = pd1;
    nxt_pair[1].old_pd = need[1] ? (byp_rd ? pd0 : map_tag[5]) : '0;
    nxt_pair[1].rd     = in_pair[1].rd;
    nxt_pair[1].writes = in_pair[1].writes;
    nxt_pair[1].jumps  = in_pair[1].jumps;
    if (in_pair[1].jumps) begin
      nxt_pair[1].tag = 1'b0;
    end else if (in_pair[0].jumps) begin
      nxt_pair[1].tag = 1'b1; // Shadow of the older jump.
    end else begin
      nxt_pair[1].tag = spec_q;
    end
  end

  always_ff @(posedge gsi or negedge rst_n) begin
    if (!rst_n) begin
      in_ack  <= 1'b0;
      out_req <= 1'b0;
      spec_q  <= 1'b0;
    end else begin
      if (accept) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end

      if (accept) begin
        out_req <= 1'b1;
      end else if (out_ack) begin
        out_req <= 1'b0;
      end

      // A new jump outranks a resolve in the same cycle.
      if (accept && (in_pair[0].jumps || in_pair[1].jumps)) begin
        spec_q <= 1'b1;
      end else if (branch_resolved) begin
        spec_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge gsi) begin
    if (accept) begin
      out_pair <= nxt_pair;
    end
  end

  // Tags from the free list must fit the configured register file.
  a_pd_range: assert property (
    @(posedge gsi) disable iff (!rst_n)
    $rose(out_req) |-> (out_pair[0].pd < NUM_PHYS) && (out_pair[1].pd < NUM_PHYS)
  ) else $error("resolver: pd out of range");

  a_out_hold: assert property (
    @(posedge gsi) disable iff (!rst_n)
    out_req && !out_ack |=> $stable(out_pair)
  ) else $error("resolver: out_pair changed under back-pressure");

endmodule

// ==== hw/rename_top.sv ====
// NUM_PHYS from 33 to 64. Retire must return only tags that were handed out or released as old_pd.
`timescale 1ns/1ns

module rename_top #(
  parameter int NUM_PHYS = 64
) (
  input  logic                          gsi,
  input  logic                          rst_n,
  input  logic                          in_req,
  input  rename_pkg::rename_in_s  [1:0] in_pair,
  output logic                          in_ack,
  output logic                          stall,
  output logic                          out_req,
  output rename_pkg::rename_out_s [1:0] out_pair,
  input  logic                          out_ack,
  input  logic                          retire_valid,
  input  rename_pkg::phys_tag_t         retire_tag,
  input  logic                          branch_resolved
);
  import rename_pkg::*;

  arch_reg_t [5:0] map_addr;
  phys_tag_t [5:0] map_tag;
  logic      [1:0] map_wr_en;
  arch_reg_t [1:0] map_wr_addr;
  phys_tag_t [1:0] map_wr_tag;
  logic      [6:0] free_count;
  phys_tag_t [1:0] alloc_tag;
  logic      [1:0] alloc_num;

  resolver #(
    .NUM_PHYS(NUM_PHYS)
  ) i_resolver (
    .gsi            (gsi),
    .rst_n          (rst_n),
    .in_req         (in_req),
    .in_pair        (in_pair),
    .in_ack         (in_ack),
    .stall          (stall),
    .out_req        (out_req),
    .out_pair       (out_pair),
    .out_ack        (out_ack),
    .branch_resolved(branch_resolved),
    .map_addr       (map_addr),
    .map_tag        (map_tag),
    .map_wr_en      (map_wr_en),
    .map_wr_addr    (map_wr_addr),
    .map_wr_tag     (map_wr_tag),
    .free_count     (free_count),
    .alloc_tag      (alloc_tag),
    .alloc_num      (alloc_num)
  );

  rename_table i_table (
    .gsi    (gsi),
    .rst_n  (rst_n),
    .rd_addr(map_addr),
    .rd_tag (map_tag),
    .wr_en  (map_wr_en),
    .wr_addr(map_wr_addr),
    .wr_tag (map_wr_tag)
  );

  free_list #(
    .NUM_PHYS(NUM_PHYS)
  ) i_free_list (
    .gsi         (gsi),
    .rst_n       (rst_n),
    .alloc_num   (alloc_num),
    .alloc_tag   (alloc_tag),
    .free_count  (free_count),
    .retire_valid(retire_valid),
    .retire_tag  (retire_tag)
  );

endmodule

// ==== include/tb_checks.svh ====
// Included inside tb_rename after its signals are declared; every wait gives up after TIMEOUT cycles.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int TIMEOUT = 64;

int          err_count   = 0;
int          check_count = 0;
int          test_count  = 0;
logic [31:0] lfsr_q      = 32'h73b8;

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
  end
endtask

function automatic logic level_of(input string name);
  if (name == "in_ack") begin
    return in_ack;
  end else if (name == "out_req") begin
    return out_req;
  end
  return stall;
endfunction

// Polls at the falling edge, where DUT outputs are settled.
task automatic wait_level(input string name, input logic val);
  int n;
  n = 0;
  while (n < TIMEOUT) begin
    @(negedge gsi);
    if (level_of(name) == val) begin
      return;
    end
    n++;
  end
  err_count++;
  $display("Timed out after %0d cycles waiting for %s to become %0d", TIMEOUT, name, val);
endtask

// Galois form, taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v      = {v[30:0], lfsr_q[0]}; // One step per bit.
    lfsr_q = lfsr_next(lfsr_q);
  end
  return v;
endfunction

task automatic finish_test(input string name, input int errs_before);
  test_count++;
  if (err_count == errs_before) begin
    $display("%s: ok", name);
  end else begin
    $display("%s: %0d errors", name, err_count - errs_before);
  end
endtask

`endif

// ==== test/tb_rename.sv ====
// Runs rename_top with 64 physical registers; the model returns only superseded old_pd tags.
`timescale 1ns/1ns

module tb_rename;
  import rename_pkg::*;

  localparam int NUM_PHYS = 64;

  logic              gsi = 1'b0;
  logic              rst_n;
  logic              in_req;
  rename_in_s  [1:0] in_pair;
  logic              in_ack;
  logic              stall;
  logic              out_req;
  rename_out_s [1:0] out_pair;
  logic              out_ack;
  logic              retire_valid;
  phys_tag_t         retire_tag;
  logic              branch_resolved;

  phys_tag_t model_map [ARCH_REGS];
  phys_tag_t free_q [$];
  logic      model_spec;

  `include "tb_checks.svh"

  always #2 gsi = ~gsi;

  rename_top #(
    .NUM_PHYS(NUM_PHYS)
  ) i_dut (
    .gsi            (gsi),
    .rst_n          (rst_n),
    .in_req         (in_req),
    .in_pair        (in_pair),
    .in_ack         (in_ack),
    .stall          (stall),
    .out_req        (out_req),
    .out_pair       (out_pair),
    .out_ack        (out_ack),
    .retire_valid   (retire_valid),
    .retire_tag     (retire_tag),
    .branch_resolved(branch_resolved)
  );

  function automatic rename_in_s insn(input int rs1, input int rs2, input int rd,
                                      input int writes, input int jumps);
    rename_in_s i;
    i.rs1    = arch_reg_t'(rs1);
    i.rs2    = arch_reg_t'(rs2);
    i.rd     = arch_reg_t'(rd);
    i.writes = 1'(writes);
    i.jumps  = 1'(jumps);
    return i;
  endfunction

  // Expected output of a pair and the model state after it is accepted.
  task automatic predict_pair(input rename_in_s [1:0] p, output rename_out_s [1:0] e);
    logic [1:0] need;
    for (int k = 0; k < 2; k++) begin
      need[k]     = p[k].writes && (p[k].rd != '0);
      e[k].rd     = p[k].rd;
      e[k].writes = p[k].writes;
      e[k].jumps  = p[k].jumps;
    end
    e[0].ps1    = model_map[p[0].rs1];
    e[0].ps2    = model_map[p[0].rs2];
    e[0].pd     = need[0] ? free_q.pop_front() : '0;
    e[0].old_pd = need[0] ? model_map[p[0].rd] : '0;
    e[1].ps1    = (need[0] && p[1].rs1 == p[0].rd) ? e[0].pd : model_map[p[1].rs1];
    e[1].ps2    = (need[0] && p[1].rs2 == p[0].rd) ? e[0].pd : model_map[p[1].rs2];
    e[1].pd     = need[1] ? free_q.pop_front() : '0;
    e[1].old_pd = !need[1] ? '0 :
                  (need[0] && p[1].rd == p[0].rd) ? e[0].pd : model_map[p[1].rd];
    e[0].tag    = p[0].jumps ? 1'b0 : model_spec;
    e[1].tag    = p[1].jumps ? 1'b0 : (p[0].jumps ? 1'b1 : model_spec);
    if (need[0]) model_map[p[0].rd] = e[0].pd;
    if (need[1]) model_map[p[1].rd] = e[1].pd; // Younger slot wins.
    if (p[0].jumps || p[1].jumps) model_spec = 1'b1;
  endtask

  task automatic compare_pair(input rename_out_s [1:0] got, input rename_out_s [1:0] exp);
    for (int k = 0; k < 2; k++) begin
      check($sformatf("out_pair[%0d].ps1", k), 32'(got[k].ps1), 32'(exp[k].ps1));
      check($sformatf("out_pair[%0d].ps2", k), 32'(got[k].ps2), 32'(exp[k].ps2));
      check($sformatf("out_pair[%0d].pd", k), 32'(got[k].pd), 32'(exp[k].pd));
      check($sformatf("out_pair[%0d].old_pd", k), 32'(got[k].old_pd), 32'(exp[k].old_pd));
      check($sformatf("out_pair[%0d].rd", k), 32'(got[k].rd), 32'(exp[k].rd));
      check($sformatf("out_pair[%0d].writes", k), 32'(got[k].writes), 32'(exp[k].writes));
      check($sformatf("out_pair[%0d].jumps", k), 32'(got[k].jumps), 32'(exp[k].jumps));
      check($sformatf("out_pair[%0d].tag", k), 32'(got[k].tag), 32'(exp[k].tag));
    end
  endtask

  task automatic raise_req(input rename_in_s [1:0] p);
    @(posedge gsi);
    in_req  <= 1'b1;
    in_pair <= p;
  endtask

  // Second half of the four-phase exchange on the decoder side.
  task automatic finish_req();
    wait_level("in_ack", 1'b1);
    @(posedge gsi);
    in_req <= 1'b0;
    wait_level("in_ack", 1'b0);
  endtask

  // Dispatch side of the exchange.
  task automatic collect(input rename_out_s [1:0] e, output rename_out_s [1:0] got);
    wait_level("out_req", 1'b1);
    got = out_pair;
    compare_pair(got, e);
    @(posedge gsi);
    out_ack <= 1'b1;
    wait_level("out_req", 1'b0);
    @(posedge gsi);
    out_ack <= 1'b0;
  endtask

  task automatic send_pair(input rename_in_s [1:0] p, output rename_out_s [1:0] got);
    rename_out_s [1:0] e;
    predict_pair(p, e);
    raise_req(p);
    finish_req();
    collect(e, got);
  endtask

  task automatic retire(input phys_tag_t t);
    @(posedge gsi);
    retire_valid <= 1'b1;
    retire_tag   <= t;
    @(posedge gsi);
    retire_valid <= 1'b0;
    free_q.push_back(t);
  endtask

  task automatic resolve_branch();
    @(posedge gsi);
    branch_resolved <= 1'b1;
    @(posedge gsi);
    branch_resolved <= 1'b0;
    model_spec = 1'b0;
  endtask

  task automatic check_tags(input rename_out_s [1:0] got, input int t0, input int t1);
    check("out_pair[0].tag", 32'(got[0].tag), t0);
    check("out_pair[1].tag", 32'(got[1].tag), t1);
  endtask

  task automatic test_independent();
    int                e0;
    rename_in_s  [1:0] p;
    rename_out_s [1:0] got;
    e0   = err_count;
    p[0] = insn(1, 2, 3, 1, 0);
    p[1] = insn(4, 5, 6, 1, 0);
    send_pair(p, got);
    check("out_pair[0].pd", 32'(got[0].pd), 32);
    check("out_pair[1].pd", 32'(got[1].pd), 33);
    check("out_pair[0].old_pd", 32'(got[0].old_pd), 3);
    p[0] = insn(7, 8, 9, 1, 0);
    p[1] = insn(10, 11, 12, 1, 0);
    send_pair(p, got); // 34 and 35 from the model.
    finish_test("independent pairs", e0);
  endtask

  task automatic test_dependent();
    int                e0;
    phys_tag_t         fwd;
    phys_tag_t         last;
    rename_in_s  [1:0] p;
    rename_out_s [1:0] got;
    e0   = err_count;
    p[0] = insn(1, 2, 5, 1, 0);
    p[1] = insn(5, 5, 5, 1, 0);
    fwd  = free_q[0]; // Both slots take tags in FIFO order.
    last = free_q[1];
    send_pair(p, got);
    check("out_pair[1].ps1", 32'(got[1].ps1), 32'(fwd));
    check("out_pair[1].ps2", 32'(got[1].ps2), 32'(fwd));
    check("out_pair[1].old_pd", 32'(got[1].old_pd), 32'(fwd));
    p[0] = insn(5, 0, 0, 0, 0);
    p[1] = insn(0, 0, 0, 0, 0);
    send_pair(p, got);
    check("out_pair[0].ps1", 32'(got[0].ps1), 32'(last));
    // Small register range so that slots collide often.
    for (int n = 0; n < 16; n++) begin
      for (int k = 0; k < 2; k++) begin
        p[k] = insn(take_bits(3), take_bits(3), take_bits(3), take_bits(1), 0);
      end
      send_pair(p, got);
      if (got[0].pd != '0) retire(got[0].old_pd);
      if (got[1].pd != '0) retire(got[1].old_pd);
    end
    finish_test("dependent pairs", e0);
  endtask

  task automatic test_no_write();
    int                e0;
    phys_tag_t         next_tag;
    rename_in_s  [1:0] p;
    rename_out_s [1:0] got;
    e0   = err_count;
    p[0] = insn(3, 4, 9, 0, 0);
    p[1] = insn(6, 7, 0, 1, 0); // Write to x0.
    next_tag = free_q[0];
    send_pair(p, got);
    for (int k = 0; k < 2; k++) begin
      check($sformatf("out_pair[%0d].pd", k), 32'(got[k].pd), 0);
      check($sformatf("out_pair[%0d].old_pd", k), 32'(got[k].old_pd), 0);
    end
    p[0] = insn(1, 1, 13, 1, 0);
    p[1] = insn(0, 0, 0, 0, 0);
    send_pair(p, got);
    check("out_pair[0].pd", 32'(got[0].pd), 32'(next_tag));
    finish_test("no-write slots", e0);
  endtask

  task automatic test_backpressure();
    int                e0;
    rename_in_s  [1:0] p;
    rename_in_s  [1:0] q;
    rename_out_s [1:0] e1;
    rename_out_s [1:0] e2;
    rename_out_s [1:0] got;
    e0   = err_count;
    p[0] = insn(2, 3, 14, 1, 0);
    p[1] = insn(14, 4, 15, 1, 0);
    q[0] = insn(15, 14, 16, 1, 0);
    q[1] = insn(16, 0, 17, 1, 0);
    predict_pair(p, e1);
    raise_req(p);
    finish_req();
    wait_level("out_req", 1'b1);
    raise_req(q);
    repeat (6) begin
      @(negedge gsi);
      compare_pair(out_pair, e1);
      check("in_ack", 32'(in_ack), 0);
    end
    predict_pair(q, e2);
    collect(e1, got);
    finish_req();
    collect(e2, got);
    finish_test("back-pressure", e0);
  endtask

  task automatic test_tags();
    int                e0;
    rename_in_s  [1:0] p;
    rename_out_s [1:0] got;
    e0   = err_count;
    p[0] = insn(1, 2, 0, 0, 1);
    p[1] = insn(3, 4, 0, 0, 0);
    send_pair(p, got);
    check_tags(got, 0, 1);
    p[0].jumps = 1'b0;
    p[1].jumps = 1'b1;
    send_pair(p, got);
    check_tags(got, 1, 0);
    p[0].jumps = 1'b1;
    send_pair(p, got);
    check_tags(got, 0, 0);
    p[0].jumps = 1'b0;
    p[1].jumps = 1'b0;
    send_pair(p, got);
    check_tags(got, 1, 1);
    resolve_branch();
    send_pair(p, got);
    check_tags(got, 0, 0);
    finish_test("speculation tags", e0);
  endtask

  task automatic test_exhaust();
    int                e0;
    phys_tag_t         t;
    rename_in_s  [1:0] p;
    rename_out_s [1:0] e;
    rename_out_s [1:0] got;
    e0 = err_count;
    while (free_q.size() >= 2) begin
      p[0] = insn(1, 2, 1 + take_bits(4), 1, 0);
      p[1] = insn(3, 4, 1 + take_bits(4), 1, 0);
      send_pair(p, got);
    end
    if (free_q.size() == 1) begin
      p[0] = insn(1, 2, 20, 1, 0);
      p[1] = insn(0, 0, 0, 0, 0);
      send_pair(p, got);
    end
    t    = got[0].old_pd; // Superseded and safe to free.
    p[0] = insn(5, 6, 21, 1, 0);
    p[1] = insn(0, 0, 0, 0, 0);
    raise_req(p);
    wait_level("stall", 1'b1);
    check("in_ack", 32'(in_ack), 0);
    retire(t);
    wait_level("stall", 1'b0);
    predict_pair(p, e);
    finish_req();
    collect(e, got);
    check("out_pair[0].pd", 32'(got[0].pd), 32'(t));
    finish_test("free list exhaustion", e0);
  endtask

  initial begin
    rst_n           <= 1'b0;
    in_req          <= 1'b0;
    in_pair         <= '0;
    out_ack         <= 1'b0;
    retire_valid    <= 1'b0;
    retire_tag      <= '0;
    branch_resolved <= 1'b0;
    for (int i = 0; i < ARCH_REGS; i++) begin
      model_map[i] = phys_tag_t'(i);
    end
    for (int t = ARCH_REGS; t < NUM_PHYS; t++) begin
      free_q.push_back(phys_tag_t'(t));
    end
    model_spec = 1'b0;
    repeat (3) @(posedge gsi);
    rst_n <= 1'b1;
    test_independent();
    test_dependent();
    test_no_write();
    test_backpressure();
    test_tags();
    test_exhaust(); // Leaves the free list empty.
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
hw/rename_pkg.sv
hw/rename_table.sv
hw/free_list.sv
hw/resolver.sv
hw/rename_top.sv
test/tb_rename.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_rename -o tb_rename

# The last command of the pipeline decides the status.
./obj_dir/tb_rename | tee /dev/stderr | grep -F "RESULT: PASS" > /dev/null
echo "Simulation passed."
